// File: logic/pcr_vault_pkg.sv
/*
 * pcr vault shared definitions
 * vault sizes, index widths, control word bit positions
 * and the host address layout
 */
package pcr_vault_pkg;

    // vault geometry
    localparam int PCR_NUM        = 4;
    localparam int PCR_NUM_DWORDS = 4;
    localparam int PCR_DATA_W     = 32;
    localparam int PCR_ENTRY_W    = 2;
    localparam int PCR_DWORD_W    = 2;
    localparam int PCR_NUM_WRITE  = 2;

    // host word address
    localparam int PCR_ADDR_W       = 6;
    localparam int ADDR_DATA_RSVD_W = PCR_ADDR_W - 1 - PCR_ENTRY_W - PCR_DWORD_W;
    localparam int ADDR_CTRL_RSVD_W = PCR_ADDR_W - 1 - PCR_ENTRY_W;

    // top address bit value that selects the control registers
    localparam logic SPACE_CTRL = 1'b1;

    // control word bit positions
    localparam int CTRL_LOCK_BIT  = 0;
    localparam int CTRL_CLEAR_BIT = 1;

    // same host address seen as a data word or as a control register
    typedef union packed {
        struct packed {
            logic                        space;
            logic [ADDR_DATA_RSVD_W-1:0] rsvd;
            logic [PCR_ENTRY_W-1:0]      entry;
            logic [PCR_DWORD_W-1:0]      dword;
        } data;
        struct packed {
            logic                        space;
            logic [ADDR_CTRL_RSVD_W-1:0] rsvd;
            logic [PCR_ENTRY_W-1:0]      entry;
        } ctrl;
    } pcr_addr_u;

endpackage

// File: logic/pcr_ctrl_regs.sv
`timescale 1ns/1ns
/*
 * pcr control registers
 * sticky per-entry lock held on the hard reset,
 * and a one-cycle clear pulse per entry
 */
module pcr_ctrl_regs (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  pwrgood_i,
    input  logic                                  ctrl_we_i,
    input  logic [pcr_vault_pkg::PCR_ENTRY_W-1:0] ctrl_entry_i,
    input  logic [1:0]                            ctrl_wdata_i,
    output logic [pcr_vault_pkg::PCR_NUM-1:0]     lock_o,
    output logic [pcr_vault_pkg::PCR_NUM-1:0]     clear_o
);

    import pcr_vault_pkg::*;

    logic [PCR_NUM-1:0] lock_q;
    logic [PCR_NUM-1:0] clear_q;
    logic [PCR_NUM-1:0] entry_sel;

    // one-hot select of the written entry
    always_comb begin
        entry_sel = '0;
        entry_sel[ctrl_entry_i] = ctrl_we_i;
    end

    // lock can only be set here, power-good drop is the only way out
    always_ff @(posedge clk) begin
        if (!pwrgood_i) begin
            lock_q <= '0;
        end else if (ctrl_wdata_i[CTRL_LOCK_BIT]) begin
            lock_q <= lock_q | entry_sel;
        end
    end

    // clear lives for one cycle only
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            clear_q <= '0;
        end else if (ctrl_wdata_i[CTRL_CLEAR_BIT]) begin
            clear_q <= entry_sel;
        end else begin
            clear_q <= '0;
        end
    end

    assign lock_o  = lock_q;
    assign clear_o = clear_q;

    // no set lock bit may fall across two cycles of good power
    lock_sticky_a: assert property (
        @(posedge clk) (pwrgood_i && $past(pwrgood_i)) |-> &(lock_q | ~$past(lock_q))
    );

endmodule

// File: logic/pcr_entry_store.sv
`timescale 1ns/1ns
/*
 * pcr entry store
 * holds the measurement words, arbitrates the crypto write clients,
 * applies entry clears and serves the consumer and host read muxes
 */
module pcr_entry_store (
    input  logic                                                      clk,
    input  logic                                                      pwrgood_i,
    input  logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0]                   wr_valid_i,
    input  logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0]
                 [pcr_vault_pkg::PCR_ENTRY_W-1:0]                     wr_entry_i,
    input  logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0]
                 [pcr_vault_pkg::PCR_DWORD_W-1:0]                     wr_dword_i,
    input  logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0]
                 [pcr_vault_pkg::PCR_DATA_W-1:0]                      wr_data_i,
    output logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0]                   wr_ready_o,
    input  logic [pcr_vault_pkg::PCR_NUM-1:0]                         clear_i,
    input  logic [pcr_vault_pkg::PCR_ENTRY_W-1:0]                     rd_entry_i,
    input  logic [pcr_vault_pkg::PCR_DWORD_W-1:0]                     rd_dword_i,
    output logic [pcr_vault_pkg::PCR_DATA_W-1:0]                      rd_data_o,
    output logic                                                      rd_last_o,
    input  logic [pcr_vault_pkg::PCR_ENTRY_W-1:0]                     host_entry_i,
    input  logic [pcr_vault_pkg::PCR_DWORD_W-1:0]                     host_dword_i,
    output logic [pcr_vault_pkg::PCR_DATA_W-1:0]                      host_rdata_o
);

    import pcr_vault_pkg::*;

    logic [PCR_DATA_W-1:0]                  pcr_q     [PCR_NUM][PCR_NUM_DWORDS];
    logic [PCR_DATA_W-1:0]                  slot_next [PCR_NUM][PCR_NUM_DWORDS];
    logic [PCR_NUM-1:0][PCR_NUM_DWORDS-1:0] slot_we;
    logic [PCR_NUM-1:0][PCR_NUM_DWORDS-1:0] slot_clash;
    logic [PCR_NUM_WRITE-1:0]               wr_accept;

    // AND-OR select of one stored word
    function automatic logic [PCR_DATA_W-1:0] read_word(
        input logic [PCR_ENTRY_W-1:0] entry,
        input logic [PCR_DWORD_W-1:0] dword
    );
        logic [PCR_DATA_W-1:0] word;
        word = '0;
        for (int e = 0; e < PCR_NUM; e++) begin
            for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                word |= {PCR_DATA_W{(entry == PCR_ENTRY_W'(e)) &&
                                    (dword == PCR_DWORD_W'(d))}} & pcr_q[e][d];
            end
        end
        return word;
    endfunction

    // clear blocks its entry, then lower client index wins a shared slot
    always_comb begin
        for (int c = 0; c < PCR_NUM_WRITE; c++) begin
            wr_ready_o[c] = !clear_i[wr_entry_i[c]];
            for (int h = 0; h < c; h++) begin
                if (wr_valid_i[h] && (wr_entry_i[h] == wr_entry_i[c]) &&
                    (wr_dword_i[h] == wr_dword_i[c])) begin
                    wr_ready_o[c] = 1'b0;
                end
            end
        end
    end

    assign wr_accept = wr_valid_i & wr_ready_o;

    // write enable and data per slot, OR-ed over all accepted clients
    always_comb begin
        logic hit;
        slot_we    = '0;
        slot_clash = '0;
        for (int e = 0; e < PCR_NUM; e++) begin
            for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                slot_next[e][d] = '0;
                for (int c = 0; c < PCR_NUM_WRITE; c++) begin
                    hit = wr_accept[c] && (wr_entry_i[c] == PCR_ENTRY_W'(e)) &&
                          (wr_dword_i[c] == PCR_DWORD_W'(d));
                    slot_clash[e][d] = slot_clash[e][d] | (hit & slot_we[e][d]);
                    slot_we[e][d]    = slot_we[e][d] | hit;
                    slot_next[e][d]  = slot_next[e][d] | ({PCR_DATA_W{hit}} & wr_data_i[c]);
                end
            end
        end
    end

    // entries survive warm reset and only fall on power-good
    always_ff @(posedge clk) begin
        for (int e = 0; e < PCR_NUM; e++) begin
            for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                if (!pwrgood_i) begin
                    pcr_q[e][d] <= '0;
                end else if (clear_i[e]) begin
                    pcr_q[e][d] <= '0;
                end else if (slot_we[e][d]) begin
                    pcr_q[e][d] <= slot_next[e][d];
                end
            end
        end
    end

    // consumer read port
    always_comb begin
        rd_data_o = read_word(rd_entry_i, rd_dword_i);
        rd_last_o = (rd_dword_i == PCR_DWORD_W'(PCR_NUM_DWORDS - 1));
    end

    // host readback
    always_comb begin
        host_rdata_o = read_word(host_entry_i, host_dword_i);
    end

    no_dual_accept_a: assert property (
        @(posedge clk) disable iff (!pwrgood_i) slot_clash == '0
    );

endmodule

// File: logic/pcr_csr_if.sv
`timescale 1ns/1ns
/*
 * pcr host CSR front end
 * captures one host request, decodes and checks it, drives the
 * control strobe and returns a registered response
 */
module pcr_csr_if (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  req_valid_i,
    output logic                                  req_ready_o,
    input  logic                                  req_write_i,
    input  logic [pcr_vault_pkg::PCR_ADDR_W-1:0]  req_addr_i,
    input  logic [pcr_vault_pkg::PCR_DATA_W-1:0]  req_wdata_i,
    output logic                                  rsp_valid_o,
    input  logic                                  rsp_ready_i,
    output logic [pcr_vault_pkg::PCR_DATA_W-1:0]  rsp_rdata_o,
    output logic                                  rsp_error_o,
    input  logic [pcr_vault_pkg::PCR_NUM-1:0]     lock_i,
    input  logic [pcr_vault_pkg::PCR_DATA_W-1:0]  host_rdata_i,
    output logic                                  ctrl_we_o,
    output logic [pcr_vault_pkg::PCR_ENTRY_W-1:0] ctrl_entry_o,
    output logic [1:0]                            ctrl_wdata_o,
    output logic [pcr_vault_pkg::PCR_ENTRY_W-1:0] host_entry_o,
    output logic [pcr_vault_pkg::PCR_DWORD_W-1:0] host_dword_o
);

    import pcr_vault_pkg::*;

    logic                  pend_q;
    logic                  pend_write_q;
    pcr_addr_u             pend_addr_q;
    logic [PCR_DATA_W-1:0] pend_wdata_q;
    logic                  rsp_valid_q;
    logic [PCR_DATA_W-1:0] rsp_rdata_q;
    logic                  rsp_error_q;
    logic                  is_ctrl;
    logic                  rsvd_err;
    logic                  lock_err;
    logic                  dec_error;
    logic [PCR_DATA_W-1:0] dec_rdata;

    // one request in flight, from capture until the response leaves
    assign req_ready_o = !pend_q && !rsp_valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= req_valid_i && req_ready_o;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            pend_write_q <= req_write_i;
            pend_addr_q  <= req_addr_i;
            pend_wdata_q <= req_wdata_i;
        end
    end

    // error rules: data writes, reserved bits, control writes to a locked entry
    always_comb begin
        is_ctrl   = (pend_addr_q.ctrl.space == SPACE_CTRL);
        rsvd_err  = is_ctrl ? (pend_addr_q.ctrl.rsvd != '0) : (pend_addr_q.data.rsvd != '0);
        lock_err  = is_ctrl && pend_write_q && lock_i[pend_addr_q.ctrl.entry];
        dec_error = rsvd_err || lock_err || (!is_ctrl && pend_write_q);
    end

    // control strobe for a legal control write only
    always_comb begin
        ctrl_we_o    = pend_q && is_ctrl && pend_write_q && !dec_error;
        ctrl_entry_o = pend_addr_q.ctrl.entry;
        ctrl_wdata_o = '0;
        ctrl_wdata_o[CTRL_LOCK_BIT]  = pend_wdata_q[CTRL_LOCK_BIT];
        ctrl_wdata_o[CTRL_CLEAR_BIT] = pend_wdata_q[CTRL_CLEAR_BIT];
    end

    assign host_entry_o = pend_addr_q.data.entry;
    assign host_dword_o = pend_addr_q.data.dword;

    // control readback shows the lock, clear always reads 0
    always_comb begin
        dec_rdata = '0;
        if (!pend_write_q && !dec_error) begin
            if (is_ctrl) begin
                dec_rdata[CTRL_LOCK_BIT] = lock_i[pend_addr_q.ctrl.entry];
            end else begin
                dec_rdata = host_rdata_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (pend_q) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pend_q) begin
            rsp_rdata_q <= dec_rdata;
            rsp_error_q <= dec_error;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_error_o = rsp_error_q;

    // a stalled response must not change under the host
    rsp_hold_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (rsp_valid_o && !rsp_ready_i) |=>
            (rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o))
    );

endmodule

// File: logic/pcr_vault.sv
`timescale 1ns/1ns
/*
 * pcr vault top
 * connects the host CSR front end, the control registers and the entry store
 */
module pcr_vault (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  pwrgood_i,
    // host request and response
    input  logic                                  req_valid_i,
    output logic                                  req_ready_o,
    input  logic                                  req_write_i,
    input  logic [pcr_vault_pkg::PCR_ADDR_W-1:0]  req_addr_i,
    input  logic [pcr_vault_pkg::PCR_DATA_W-1:0]  req_wdata_i,
    output logic                                  rsp_valid_o,
    input  logic                                  rsp_ready_i,
    output logic [pcr_vault_pkg::PCR_DATA_W-1:0]  rsp_rdata_o,
    output logic                                  rsp_error_o,
    // crypto write clients
    input  logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0] wr_valid_i,
    input  logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0]
                 [pcr_vault_pkg::PCR_ENTRY_W-1:0]   wr_entry_i,
    input  logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0]
                 [pcr_vault_pkg::PCR_DWORD_W-1:0]   wr_dword_i,
    input  logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0]
                 [pcr_vault_pkg::PCR_DATA_W-1:0]    wr_data_i,
    output logic [pcr_vault_pkg::PCR_NUM_WRITE-1:0] wr_ready_o,
    // consumer read port
    input  logic [pcr_vault_pkg::PCR_ENTRY_W-1:0] rd_entry_i,
    input  logic [pcr_vault_pkg::PCR_DWORD_W-1:0] rd_dword_i,
    output logic [pcr_vault_pkg::PCR_DATA_W-1:0]  rd_data_o,
    output logic                                  rd_last_o
);

    import pcr_vault_pkg::*;

    logic                   ctrl_we;
    logic [PCR_ENTRY_W-1:0] ctrl_entry;
    logic [1:0]             ctrl_wdata;
    logic [PCR_NUM-1:0]     lock;
    logic [PCR_NUM-1:0]     clear;
    logic [PCR_ENTRY_W-1:0] host_entry;
    logic [PCR_DWORD_W-1:0] host_dword;
    logic [PCR_DATA_W-1:0]  host_rdata;

    pcr_csr_if i_csr_if (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_rdata_o  (rsp_rdata_o),
        .rsp_error_o  (rsp_error_o),
        .lock_i       (lock),
        .host_rdata_i (host_rdata),
        .ctrl_we_o    (ctrl_we),
        .ctrl_entry_o (ctrl_entry),
        .ctrl_wdata_o (ctrl_wdata),
        .host_entry_o (host_entry),
        .host_dword_o (host_dword)
    );

    pcr_ctrl_regs i_ctrl_regs (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pwrgood_i    (pwrgood_i),
        .ctrl_we_i    (ctrl_we),
        .ctrl_entry_i (ctrl_entry),
        .ctrl_wdata_i (ctrl_wdata),
        .lock_o       (lock),
        .clear_o      (clear)
    );

    pcr_entry_store i_entry_store (
        .clk          (clk),
        .pwrgood_i    (pwrgood_i),
        .wr_valid_i   (wr_valid_i),
        .wr_entry_i   (wr_entry_i),
        .wr_dword_i   (wr_dword_i),
        .wr_data_i    (wr_data_i),
        .wr_ready_o   (wr_ready_o),
        .clear_i      (clear),
        .rd_entry_i   (rd_entry_i),
        .rd_dword_i   (rd_dword_i),
        .rd_data_o    (rd_data_o),
        .rd_last_o    (rd_last_o),
        .host_entry_i (host_entry),
        .host_dword_i (host_dword),
        .host_rdata_o (host_rdata)
    );

endmodule

// File: tests/tb_clkgen.sv
`timescale 1ns/1ns
/*
 * testbench clock generator
 * free-running clock, low at the start
 */
module tb_clkgen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

endmodule

// File: tests/tb_pcr_vault.sv
`timescale 1ns/1ns
/*
 * pcr vault testbench
 * client fill and read port, collision priority, host reads and errors,
 * response back-pressure, lock and clear, warm reset and power-good drop
 */
module tb_pcr_vault;

    import pcr_vault_pkg::*;

    typedef struct packed {
        logic                  error;
        logic [PCR_DATA_W-1:0] rdata;
    } host_rsp_t;

    localparam int CLK_PERIOD_NS = 40;
    localparam int NUM_SLOTS     = PCR_NUM * PCR_NUM_DWORDS;
    localparam int BP_REQS       = 8;
    localparam int BP_MAX_STALL  = 6;
    localparam int HOST_CYCLES   = 5;
    localparam int HOST_OPS      = 2 * NUM_SLOTS + 20;
    // one fill, five read sweeps, collision, host traffic, stalls and resets
    localparam int TEST_CYCLES   = NUM_SLOTS * 3 + 5 * NUM_SLOTS + 10 +
                                   HOST_OPS * HOST_CYCLES +
                                   BP_REQS * (HOST_CYCLES + BP_MAX_STALL) + 30;
    localparam int WATCHDOG_NS   = CLK_PERIOD_NS * TEST_CYCLES * 2;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     pwrgood;
    logic                                     req_valid;
    logic                                     req_ready;
    logic                                     req_write;
    pcr_addr_u                                req_addr;
    logic [PCR_DATA_W-1:0]                    req_wdata;
    logic                                     rsp_valid;
    logic                                     rsp_ready;
    logic [PCR_DATA_W-1:0]                    rsp_rdata;
    logic                                     rsp_error;
    logic [PCR_NUM_WRITE-1:0]                 wr_valid;
    logic [PCR_NUM_WRITE-1:0][PCR_ENTRY_W-1:0] wr_entry;
    logic [PCR_NUM_WRITE-1:0][PCR_DWORD_W-1:0] wr_dword;
    logic [PCR_NUM_WRITE-1:0][PCR_DATA_W-1:0]  wr_data;
    logic [PCR_NUM_WRITE-1:0]                 wr_ready;
    logic [PCR_ENTRY_W-1:0]                   rd_entry;
    logic [PCR_DWORD_W-1:0]                   rd_dword;
    logic [PCR_DATA_W-1:0]                    rd_data;
    logic                                     rd_last;

    // shadow state of the vault
    logic [PCR_DATA_W-1:0] shadow [PCR_NUM][PCR_NUM_DWORDS];
    logic [PCR_NUM-1:0]    shadow_lock;
    host_rsp_t             exp_q [$];
    integer                seed;
    int                    err_count;
    int                    req_count;
    int                    rsp_count;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS)) i_clkgen (.clk_o(clk));

    pcr_vault i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .pwrgood_i   (pwrgood),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_write_i (req_write),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_rdata_o (rsp_rdata),
        .rsp_error_o (rsp_error),
        .wr_valid_i  (wr_valid),
        .wr_entry_i  (wr_entry),
        .wr_dword_i  (wr_dword),
        .wr_data_i   (wr_data),
        .wr_ready_o  (wr_ready),
        .rd_entry_i  (rd_entry),
        .rd_dword_i  (rd_dword),
        .rd_data_o   (rd_data),
        .rd_last_o   (rd_last)
    );

    task automatic check_word(input string name, input logic [PCR_DATA_W-1:0] got,
                              input logic [PCR_DATA_W-1:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input host_rsp_t got, input host_rsp_t exp);
        if (got !== exp) begin
            err_count++;
            $display("error: %s got rdata 0x%08h error 0x%0h expected rdata 0x%08h error 0x%0h",
                     name, got.rdata, got.error, exp.rdata, exp.error);
        end
    endtask

    function automatic pcr_addr_u data_addr(input int e, input int d);
        pcr_addr_u a;
        a            = '0;
        a.data.space = ~SPACE_CTRL;
        a.data.entry = PCR_ENTRY_W'(e);
        a.data.dword = PCR_DWORD_W'(d);
        return a;
    endfunction

    function automatic pcr_addr_u ctrl_addr(input int e);
        pcr_addr_u a;
        a            = '0;
        a.ctrl.space = SPACE_CTRL;
        a.ctrl.entry = PCR_ENTRY_W'(e);
        return a;
    endfunction

    // expected host response from the request and the shadow state
    function automatic host_rsp_t expected_rsp(input logic write, input pcr_addr_u addr);
        host_rsp_t rsp;
        rsp = '0;
        if (addr.ctrl.space == SPACE_CTRL) begin
            if (addr.ctrl.rsvd != '0 || (write && shadow_lock[addr.ctrl.entry])) begin
                rsp.error = 1'b1;
            end else if (!write) begin
                rsp.rdata[CTRL_LOCK_BIT] = shadow_lock[addr.ctrl.entry];
            end
        end else if (write || addr.data.rsvd != '0) begin
            rsp.error = 1'b1;
        end else begin
            rsp.rdata = shadow[addr.data.entry][addr.data.dword];
        end
        return rsp;
    endfunction

    task automatic client_write(input int c, input int e, input int d,
                                input logic [PCR_DATA_W-1:0] data);
        @(negedge clk);
        wr_valid[c] = 1'b1;
        wr_entry[c] = PCR_ENTRY_W'(e);
        wr_dword[c] = PCR_DWORD_W'(d);
        wr_data[c]  = data;
        #1;
        while (!wr_ready[c]) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        wr_valid[c] = 1'b0;
        shadow[e][d] = data;
    endtask

    task automatic fill_random();
        logic [PCR_DATA_W-1:0] data;
        int                    c;
        for (int e = 0; e < PCR_NUM; e++) begin
            for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                data = $random(seed);
                c    = $random(seed) & 1;
                client_write(c, e, d, data);
            end
        end
    endtask

    task automatic read_check(input int e, input int d);
        @(negedge clk);
        rd_entry = PCR_ENTRY_W'(e);
        rd_dword = PCR_DWORD_W'(d);
        #1;
        check_word("rd_data_o", rd_data, shadow[e][d]);
        check_flag("rd_last_o", rd_last, d == PCR_NUM_DWORDS - 1);
    endtask

    task automatic read_all();
        for (int e = 0; e < PCR_NUM; e++) begin
            for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                read_check(e, d);
            end
        end
    endtask

    // one host request, response held back for stall cycles
    task automatic host_access(input logic write, input pcr_addr_u addr,
                               input logic [PCR_DATA_W-1:0] wdata, input int stall);
        host_rsp_t exp;
        exp = expected_rsp(write, addr);
        @(negedge clk);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        rsp_ready = (stall == 0);
        while (!req_ready) begin
            @(negedge clk);
        end
        exp_q.push_back(exp);
        req_count++;
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) begin
            @(negedge clk);
        end
        for (int i = 0; i < stall; i++) begin
            check_rsp("rsp_rdata_o/rsp_error_o", {rsp_error, rsp_rdata}, exp);
            check_flag("req_ready_o", req_ready, 1'b0);
            @(negedge clk);
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        check_flag("rsp_valid_o", rsp_valid, 1'b0);
        if (write && !exp.error) begin
            if (wdata[CTRL_LOCK_BIT]) begin
                shadow_lock[addr.ctrl.entry] = 1'b1;
            end
            if (wdata[CTRL_CLEAR_BIT]) begin
                for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                    shadow[addr.ctrl.entry][d] = '0;
                end
            end
        end
    endtask

    // a read response is left waiting so that the reset has state to drop
    task automatic warm_reset();
        @(negedge clk);
        req_valid = 1'b1;
        req_write = 1'b0;
        req_addr  = ctrl_addr(0);
        rsp_ready = 1'b0;
        @(negedge clk);
        req_valid = 1'b0;
        @(negedge clk);
        check_flag("rsp_valid_o", rsp_valid, 1'b1);
        rst_n = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag("req_ready_o", req_ready, 1'b1);
            check_flag("rsp_valid_o", rsp_valid, 1'b0);
        end
        rst_n     = 1'b1;
        rsp_ready = 1'b1;
    endtask

    task automatic power_cycle();
        @(negedge clk);
        pwrgood = 1'b0;
        repeat (2) @(negedge clk);
        pwrgood     = 1'b1;
        shadow_lock = '0;
        for (int e = 0; e < PCR_NUM; e++) begin
            for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                shadow[e][d] = '0;
            end
        end
    endtask

    // compares every host response that transfers
    initial begin
        host_rsp_t exp;
        forever begin
            @(negedge clk);
            #(CLK_PERIOD_NS / 4);
            if (rsp_valid && rsp_ready) begin
                rsp_count++;
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("host response arrived with no request outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    check_rsp("rsp_rdata_o/rsp_error_o", {rsp_error, rsp_rdata}, exp);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        $display("errors: %0d requests: %0d responses: %0d", err_count, req_count, rsp_count);
        $display("sim failed");
        $finish;
    end

    initial begin
        pcr_addr_u             addr;
        logic [PCR_DATA_W-1:0] d0;
        logic [PCR_DATA_W-1:0] d1;
        seed      = 14;
        err_count = 0;
        req_count = 0;
        rsp_count = 0;
        rst_n     = 1'b0;
        pwrgood   = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_ready = 1'b1;
        wr_valid  = '0;
        wr_entry  = '0;
        wr_dword  = '0;
        wr_data   = '0;
        rd_entry  = '0;
        rd_dword  = '0;
        shadow_lock = '0;
        for (int e = 0; e < PCR_NUM; e++) begin
            for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                shadow[e][d] = '0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("req_ready_o", req_ready, 1'b1);
        check_flag("rsp_valid_o", rsp_valid, 1'b0);
        rst_n   = 1'b1;
        pwrgood = 1'b1;

        fill_random();
        read_all();

        // both clients on entry 3 dword 1, client 0 goes first
        d0 = $random(seed);
        d1 = $random(seed);
        @(negedge clk);
        wr_valid = '1;
        wr_entry = {2{PCR_ENTRY_W'(3)}};
        wr_dword = {2{PCR_DWORD_W'(1)}};
        wr_data  = {d1, d0};
        rd_entry = PCR_ENTRY_W'(3);
        rd_dword = PCR_DWORD_W'(1);
        #1;
        check_flag("wr_ready_o[0]", wr_ready[0], 1'b1);
        check_flag("wr_ready_o[1]", wr_ready[1], 1'b0);
        @(negedge clk);
        wr_valid[0] = 1'b0;
        #1;
        check_word("rd_data_o", rd_data, d0);
        check_flag("wr_ready_o[1]", wr_ready[1], 1'b1);
        @(negedge clk);
        wr_valid[1] = 1'b0;
        #1;
        check_word("rd_data_o", rd_data, d1);
        shadow[3][1] = d1;

        // host data reads and rejected requests
        for (int e = 0; e < PCR_NUM; e++) begin
            for (int d = 0; d < PCR_NUM_DWORDS; d++) begin
                host_access(1'b0, data_addr(e, d), '0, 0);
            end
        end
        host_access(1'b1, data_addr(1, 2), $random(seed), 0);
        addr           = data_addr(0, 1);
        addr.data.rsvd = 1'b1;
        host_access(1'b0, addr, '0, 0);
        addr           = ctrl_addr(3);
        addr.ctrl.rsvd = 3'b010;
        host_access(1'b1, addr, 32'h1, 0);
        host_access(1'b0, ctrl_addr(3), '0, 0);
        read_all();

        for (int i = 0; i < BP_REQS; i++) begin
            addr = PCR_ADDR_W'($random(seed));
            host_access(1'b0, addr, '0, 1 + ($unsigned($random(seed)) % BP_MAX_STALL));
        end

        // clear entry 1, lock entry 2, then try to change the locked entry
        host_access(1'b1, ctrl_addr(1), 32'h1 << CTRL_CLEAR_BIT, 0);
        host_access(1'b0, ctrl_addr(1), '0, 0);
        host_access(1'b1, ctrl_addr(2), 32'h1 << CTRL_LOCK_BIT, 0);
        host_access(1'b0, ctrl_addr(2), '0, 0);
        host_access(1'b1, ctrl_addr(2), 32'h1 << CTRL_CLEAR_BIT, 0);
        host_access(1'b1, ctrl_addr(2), '0, 0);
        read_all();
        warm_reset();
        host_access(1'b0, ctrl_addr(2), '0, 0);
        read_all();
        power_cycle();
        host_access(1'b0, ctrl_addr(2), '0, 0);
        read_all();

        repeat (2) @(negedge clk);
        if (exp_q.size() != 0 || rsp_count != req_count) begin
            err_count++;
            $display("host responses do not match requests one for one");
        end
        $display("errors: %0d requests: %0d responses: %0d", err_count, req_count, rsp_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: files.f
logic/pcr_vault_pkg.sv
logic/pcr_ctrl_regs.sv
logic/pcr_entry_store.sv
logic/pcr_csr_if.sv
logic/pcr_vault.sv
tests/tb_clkgen.sv
tests/tb_pcr_vault.sv

// File: Bender.yml
package:
  name: pcr_vault

sources:
  - files:
      - logic/pcr_vault_pkg.sv
      - logic/pcr_ctrl_regs.sv
      - logic/pcr_entry_store.sv
      - logic/pcr_csr_if.sv
      - logic/pcr_vault.sv
  - target: test
    files:
      - tests/tb_clkgen.sv
      - tests/tb_pcr_vault.sv
